//--- verilog/definitions.sv
package definitions;

    // data widths
    typedef logic [31:0] word_t;    // operands and results
    typedef logic [6:0]  funct7_t;
    typedef logic [2:0]  funct3_t;

    // single-bit status
    typedef logic flag_t;

    localparam flag_t LOW  = 1'b0;
    localparam flag_t HIGH = 1'b1;

    // alu class as given by the main decoder
    typedef enum logic [1:0] {
        TYPE_R  = 2'd0,     // register-register
        TYPE_I  = 2'd1,     // register-immediate
        DEF_ADD = 2'd2,     // plain add, address calc and the like
        PASS_S1 = 2'd3      // forward source 1 untouched
    } aluOp_t;

    // operation carried to the execute stage
    typedef enum logic [4:0] {
        ADD    = 5'd0,
        SUB    = 5'd1,
        SLL    = 5'd2,
        SLT    = 5'd3,
        SLTU   = 5'd4,
        XOR    = 5'd5,
        SRL    = 5'd6,
        SRA    = 5'd7,
        OR     = 5'd8,
        AND    = 5'd9,
        // RV32M
        MUL    = 5'd10,
        MULH   = 5'd11,
        MULHSU = 5'd12,
        MULHU  = 5'd13,
        DIV    = 5'd14,
        DIVU   = 5'd15,
        REM    = 5'd16,
        REMU   = 5'd17,
        FWD    = 5'd18      // result is srcA
    } alu_operation_t;

endpackage : definitions

//--- verilog/aluOpSel.sv
module aluOpSel
    import definitions::*;
(
    input  aluOp_t         aluOp,
    input  funct7_t        funct7,
    input  funct3_t        funct3,
    output alu_operation_t opSel,
    output flag_t          error
);

    // funct7 groups
    localparam funct7_t BASE_OPS = 7'd0;    // RV32I
    localparam funct7_t MULT_OPS = 7'd1;    // RV32M
    localparam funct7_t ALT_OPS  = 7'd32;   // sub / sra

    // funct3 of the base integer ops
    localparam funct3_t F3_ADD_SUB = 3'd0;
    localparam funct3_t F3_SLL     = 3'd1;
    localparam funct3_t F3_SLT     = 3'd2;
    localparam funct3_t F3_SLTU    = 3'd3;
    localparam funct3_t F3_XOR     = 3'd4;
    localparam funct3_t F3_SRL_SRA = 3'd5;
    localparam funct3_t F3_OR      = 3'd6;
    localparam funct3_t F3_AND     = 3'd7;

    alu_operation_t baseOp;

    // funct3 to op for funct7 == 0, shared by R and I type
    always_comb begin
        case (funct3)
            F3_ADD_SUB : baseOp = ADD;
            F3_SLL     : baseOp = SLL;
            F3_SLT     : baseOp = SLT;
            F3_SLTU    : baseOp = SLTU;     // SLTIU on the I side
            F3_XOR     : baseOp = XOR;
            F3_SRL_SRA : baseOp = SRL;
            F3_OR      : baseOp = OR;
            F3_AND     : baseOp = AND;
            default    : baseOp = ADD;
        endcase
    end

    always_comb begin
        opSel = ADD;
        error = LOW;
        case (aluOp)
            TYPE_R: begin
                case (funct7)
                    BASE_OPS : opSel = baseOp;
                    ALT_OPS : begin
                        case (funct3)
                            F3_ADD_SUB : opSel = SUB;
                            F3_SRL_SRA : opSel = SRA;
                            default : begin
                                opSel = ADD;
                                error = HIGH;
                            end
                        endcase
                    end
                    MULT_OPS : begin
                        // funct3 order follows the M extension encoding
                        case (funct3)
                            3'd0    : opSel = MUL;
                            3'd1    : opSel = MULH;
                            3'd2    : opSel = MULHSU;
                            3'd3    : opSel = MULHU;
                            3'd4    : opSel = DIV;
                            3'd5    : opSel = DIVU;
                            3'd6    : opSel = REM;
                            default : opSel = REMU;
                        endcase
                    end
                    default : begin
                        opSel = ADD;
                        error = HIGH;
                    end
                endcase
            end
            TYPE_I: begin
                case (funct7)
                    BASE_OPS : opSel = baseOp;
                    ALT_OPS : begin
                        if (funct3 == F3_SRL_SRA) begin
                            opSel = SRA;    // srai
                        end else begin
                            opSel = ADD;
                            error = HIGH;
                        end
                    end
                    default : begin
                        opSel = ADD;
                        error = HIGH;
                    end
                endcase
            end
            DEF_ADD : opSel = ADD;
            PASS_S1 : opSel = FWD;
            default : begin
                opSel = ADD;
                error = HIGH;
            end
        endcase
    end

endmodule : aluOpSel

//--- verilog/opDecodeStage.sv
module opDecodeStage
    import definitions::*;
(
    input  logic           clk,
    input  logic           rst,
    // request side
    input  logic           inValid,
    output logic           inReady,
    input  aluOp_t         aluOp,
    input  funct7_t        funct7,
    input  funct3_t        funct3,
    input  word_t          srcA,
    input  word_t          srcB,
    // decoded side
    output logic           decValid,
    input  logic           decReady,
    output alu_operation_t decOp,
    output flag_t          decErr,
    output word_t          decA,
    output word_t          decB
);

    alu_operation_t selOp;
    flag_t          selErr;
    logic           accept;

    aluOpSel opSelInst (
        .aluOp (aluOp),
        .funct7(funct7),
        .funct3(funct3),
        .opSel (selOp),
        .error (selErr)
    );

    // slice empty, or its content leaves this cycle
    assign inReady = !decValid || decReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (accept) begin
            decValid <= 1'b1;
        end else if (decReady) begin
            decValid <= 1'b0;   // drained, nothing new
        end
    end

    // payload, loaded only on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            decOp  <= selOp;
            decErr <= selErr;
            decA   <= srcA;
            decB   <= srcB;
        end
    end

    // a stalled item must not change under the FIFO
    decHoldStable: assert property (
        @(posedge clk) disable iff (rst)
        decValid && !decReady |=> decValid && $stable({decOp, decErr, decA, decB})
    ) else $error("decoded output changed while stalled");

endmodule : opDecodeStage

//--- verilog/opFifo.sv
module opFifo
    import definitions::*;
#(
    parameter int FIFO_DEPTH = 4    // power of two, 2 or more
) (
    input  logic           clk,
    input  logic           rst,
    // write side
    input  logic           decValid,
    output logic           decReady,
    input  alu_operation_t decOp,
    input  flag_t          decErr,
    input  word_t          decA,
    input  word_t          decB,
    // read side
    output logic           qValid,
    input  logic           qReady,
    output alu_operation_t qOp,
    output flag_t          qErr,
    output word_t          qA,
    output word_t          qB
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    alu_operation_t opMem [FIFO_DEPTH];
    flag_t          errMem [FIFO_DEPTH];
    word_t          aMem [FIFO_DEPTH];
    word_t          bMem [FIFO_DEPTH];

    ptr_t             wrPtr;
    ptr_t             rdPtr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wrEn;
    logic             rdEn;

    assign full   = (count == FIFO_DEPTH);
    assign qValid = (count != '0);     // no fall-through
    // when full, a read in the same cycle frees the slot being written
    assign decReady = !full || qReady;

    assign wrEn = decValid && decReady;
    assign rdEn = qValid && qReady;

    // head of queue
    assign qOp = opMem[rdPtr];
    assign qErr = errMem[rdPtr];
    assign qA  = aMem[rdPtr];
    assign qB  = bMem[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) wrPtr <= wrPtr + 1'b1;   // wraps at depth
            if (rdEn) rdPtr <= rdPtr + 1'b1;
            case ({wrEn, rdEn})
                2'b10   : count <= count + 1'b1;
                2'b01   : count <= count - 1'b1;
                default : count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            opMem[wrPtr]  <= decOp;
            errMem[wrPtr] <= decErr;
            aMem[wrPtr]   <= decA;
            bMem[wrPtr]   <= decB;
        end
    end

    countInRange: assert property (
        @(posedge clk) disable iff (rst) count <= FIFO_DEPTH
    ) else $error("fifo count above depth");

endmodule : opFifo

//--- verilog/aluExecStage.sv
module aluExecStage
    import definitions::*;
(
    input  logic           clk,
    input  logic           rst,
    // from the FIFO
    input  logic           qValid,
    output logic           qReady,
    input  alu_operation_t qOp,
    input  flag_t          qErr,
    input  word_t          qA,
    input  word_t          qB,
    // result side
    output logic           resValid,
    input  logic           resReady,
    output word_t          result,
    output flag_t          error
);

    localparam word_t MIN_INT = 32'h8000_0000;
    localparam word_t ALL_ONES = 32'hffff_ffff;

    logic [4:0]  shamt;
    logic [63:0] prodSS;        // signed x signed
    logic [63:0] prodSU;        // signed x unsigned
    logic [63:0] prodUU;
    logic        divByZero;
    logic        divOverflow;   // MIN_INT / -1
    word_t       safeB;
    word_t       quotS;
    word_t       remS;
    word_t       quotU;
    word_t       remU;
    word_t       aluOut;
    logic        accept;

    assign shamt = qB[4:0];

    // operands widened by hand, low 64 bits of the product are exact
    assign prodSS = {{32{qA[31]}}, qA} * {{32{qB[31]}}, qB};
    assign prodSU = {{32{qA[31]}}, qA} * {32'b0, qB};
    assign prodUU = {32'b0, qA} * {32'b0, qB};

    assign divByZero   = (qB == '0);
    assign divOverflow = (qA == MIN_INT) && (qB == ALL_ONES);

    // dividing by one when the divisor is zero keeps the dividers free of x
    assign safeB = divByZero ? 32'd1 : qB;
    assign quotS = $signed(qA) / $signed(safeB);
    assign remS  = $signed(qA) % $signed(safeB);
    assign quotU = qA / safeB;
    assign remU  = qA % safeB;

    always_comb begin
        case (qOp)
            ADD    : aluOut = qA + qB;
            SUB    : aluOut = qA - qB;
            SLL    : aluOut = qA << shamt;
            SLT    : aluOut = {31'b0, $signed(qA) < $signed(qB)};
            SLTU   : aluOut = {31'b0, qA < qB};
            XOR    : aluOut = qA ^ qB;
            SRL    : aluOut = qA >> shamt;
            SRA    : aluOut = $signed(qA) >>> shamt;
            OR     : aluOut = qA | qB;
            AND    : aluOut = qA & qB;
            MUL    : aluOut = prodUU[31:0];   // low half is sign agnostic
            MULH   : aluOut = prodSS[63:32];
            MULHSU : aluOut = prodSU[63:32];
            MULHU  : aluOut = prodUU[63:32];
            DIV: begin
                if (divByZero)
                    aluOut = ALL_ONES;
                else if (divOverflow)
                    aluOut = qA;            // quotient stays MIN_INT
                else
                    aluOut = quotS;
            end
            DIVU   : aluOut = divByZero ? ALL_ONES : quotU;
            REM: begin
                if (divByZero)
                    aluOut = qA;
                else if (divOverflow)
                    aluOut = '0;
                else
                    aluOut = remS;
            end
            REMU   : aluOut = divByZero ? qA : remU;
            FWD    : aluOut = qA;
            default: aluOut = '0;
        endcase
    end

    assign qReady = !resValid || resReady;
    assign accept = qValid && qReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else if (accept) begin
            resValid <= 1'b1;
        end else if (resReady) begin
            resValid <= 1'b0;
        end
    end

    // illegal encodings report zero
    always_ff @(posedge clk) begin
        if (accept) begin
            result <= qErr ? '0 : aluOut;
            error  <= qErr;
        end
    end

    resHoldStable: assert property (
        @(posedge clk) disable iff (rst)
        resValid && !resReady |=> resValid && $stable({result, error})
    ) else $error("result changed while stalled");

endmodule : aluExecStage

//--- verilog/execUnit.sv
module execUnit
    import definitions::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst,
    // request
    input  logic    inValid,
    output logic    inReady,
    input  aluOp_t  aluOp,
    input  funct7_t funct7,
    input  funct3_t funct3,
    input  word_t   srcA,
    input  word_t   srcB,
    // result
    output logic    resValid,
    input  logic    resReady,
    output word_t   result,
    output flag_t   error
);

    // decode stage to FIFO
    logic           decValid;
    logic           decReady;
    alu_operation_t decOp;
    flag_t          decErr;
    word_t          decA;
    word_t          decB;

    // FIFO to execute
    logic           qValid;
    logic           qReady;
    alu_operation_t qOp;
    flag_t          qErr;
    word_t          qA;
    word_t          qB;

    opDecodeStage decodeInst (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .inReady (inReady),
        .aluOp   (aluOp),
        .funct7  (funct7),
        .funct3  (funct3),
        .srcA    (srcA),
        .srcB    (srcB),
        .decValid(decValid),
        .decReady(decReady),
        .decOp   (decOp),
        .decErr  (decErr),
        .decA    (decA),
        .decB    (decB)
    );

    opFifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifoInst (
        .clk     (clk),
        .rst     (rst),
        .decValid(decValid),
        .decReady(decReady),
        .decOp   (decOp),
        .decErr  (decErr),
        .decA    (decA),
        .decB    (decB),
        .qValid  (qValid),
        .qReady  (qReady),
        .qOp     (qOp),
        .qErr    (qErr),
        .qA      (qA),
        .qB      (qB)
    );

    aluExecStage execInst (
        .clk     (clk),
        .rst     (rst),
        .qValid  (qValid),
        .qReady  (qReady),
        .qOp     (qOp),
        .qErr    (qErr),
        .qA      (qA),
        .qB      (qB),
        .resValid(resValid),
        .resReady(resReady),
        .result  (result),
        .error   (error)
    );

endmodule : execUnit

//--- tb/execUnitTb.sv
module execUnitTb
    import definitions::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;   // cycles per wait

    logic    clk;
    logic    rst;
    logic    inValid;
    logic    inReady;
    aluOp_t  aluOp;
    funct7_t funct7;
    funct3_t funct3;
    word_t   srcA;
    word_t   srcB;
    logic    resValid;
    logic    resReady;
    word_t   result;
    flag_t   error;

    // cases from the data file
    string      caseName [$];
    logic [1:0] caseClass [$];
    funct7_t    caseF7 [$];
    funct3_t    caseF3 [$];
    word_t      caseA [$];
    word_t      caseB [$];
    word_t      caseRes [$];
    flag_t      caseErr [$];

    // expectations of accepted requests in issue order
    string expName [$];
    word_t expRes [$];
    flag_t expErr [$];

    logic [31:0] bpState  = 32'h251e;
    logic [31:0] gapState = 32'h251e;
    logic        randomBp = 1'b0;

    execUnit #(.FIFO_DEPTH(4)) uut (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .aluOp(aluOp),
        .funct7(funct7), .funct3(funct3), .srcA(srcA), .srcB(srcB),
        .resValid(resValid), .resReady(resReady), .result(result), .error(error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (expected !== actual)
            stopRun($sformatf("** Error: %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic checkFlag(input string name, input flag_t expected, input flag_t actual);
        if (expected !== actual)
            stopRun($sformatf("** Error: %s: expected %b, actual %b", name, expected, actual));
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (expected != actual)
            stopRun($sformatf("** Error: %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    task automatic readCases();
        int fd;
        int n;
        string line;
        string name;
        logic [31:0] cls;
        logic [31:0] f7;
        logic [31:0] f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] e;
        fd = $fopen("tb/execUnit_cases.txt", "r");
        if (fd == 0) stopRun("could not open the case file tb/execUnit_cases.txt");
        while ($fgets(line, fd)) begin
            if (line.len() <= 1 || line.substr(0, 0) == "#") continue;   // blank or comment
            n = $sscanf(line, "%s %h %h %h %h %h %h %h", name, cls, f7, f3, a, b, r, e);
            if (n != 8) stopRun($sformatf("malformed line in case file: %s", line));
            caseName.push_back(name);
            caseClass.push_back(cls[1:0]);
            caseF7.push_back(f7[6:0]);
            caseF3.push_back(f3[2:0]);
            caseA.push_back(a);
            caseB.push_back(b);
            caseRes.push_back(r);
            caseErr.push_back(e[0]);
        end
        $fclose(fd);
    endtask

    // drive one request and wait for its handshake
    task automatic issueCase(input int i);
        int waited;
        waited = 0;
        @(negedge clk);
        inValid = 1'b1;
        aluOp   = aluOp_t'(caseClass[i]);
        funct7  = caseF7[i];
        funct3  = caseF3[i];
        srcA    = caseA[i];
        srcB    = caseB[i];
        @(posedge clk);
        while (!inReady) begin
            waited++;
            if (waited > TIMEOUT) stopRun("request handshake stalled, inReady never rose");
            @(posedge clk);
        end
        expName.push_back(caseName[i]);
        expRes.push_back(caseRes[i]);
        expErr.push_back(caseErr[i]);
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expName.size() != 0) begin
            @(negedge clk);
            inValid = 1'b0;
            waited++;
            if (waited > TIMEOUT) stopRun("result handshake stalled, results still outstanding");
        end
    endtask

    // random back-pressure on the result port
    always @(negedge clk) begin
        if (randomBp) begin
            bpState  = lcgNext(bpState);
            resReady = (bpState[17:16] != 2'b00);   // ready about 3 cycles in 4
        end
    end

    // result transfers checked in issue order
    always @(posedge clk) begin : resultMonitor
        string name;
        if (!rst && resValid && resReady) begin
            if (expName.size() == 0) stopRun("result arrived with no request outstanding");
            name = expName.pop_front();
            checkWord(name, expRes.pop_front(), result);
            checkFlag({name, " error"}, expErr.pop_front(), error);
        end
    end

    initial begin : stimulus
        int cycles;
        rst      = 1'b1;
        inValid  = 1'b0;
        aluOp    = TYPE_R;
        funct7   = '0;
        funct3   = '0;
        srcA     = '0;
        srcB     = '0;
        resReady = 1'b0;
        readCases();
        if (caseName.size() == 0) stopRun("case file holds no cases");
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkFlag("reset resValid", LOW, resValid);
        checkFlag("reset inReady", HIGH, inReady);

        // fixed latency on an idle path that is always ready
        resReady = 1'b1;
        issueCase(0);
        cycles = 0;
        do begin
            @(negedge clk);
            inValid = 1'b0;
            cycles++;
            if (cycles > TIMEOUT) stopRun("resValid never rose after a single request");
        end while (!resValid);
        checkCount("request to result latency", 3, cycles);
        waitDrain();

        // two passes with gaps and back-pressure
        randomBp = 1'b1;
        for (int pass = 0; pass < 2; pass++) begin
            foreach (caseName[i]) begin
                issueCase(i);
                gapState = lcgNext(gapState);
                if (gapState[18:17] == 2'b00) begin
                    @(negedge clk);
                    inValid = 1'b0;
                    repeat (gapState[20:19]) @(negedge clk);
                end
            end
        end
        waitDrain();

        // no further result once every request is answered
        @(negedge clk);
        randomBp = 1'b0;
        resReady = 1'b1;
        repeat (4) @(negedge clk);
        checkFlag("resValid after drain", LOW, resValid);

        $display("Verification passed");
        $finish;
    end

endmodule : execUnitTb

//--- execUnit.f
verilog/definitions.sv
verilog/aluOpSel.sv
verilog/opDecodeStage.sv
verilog/opFifo.sv
verilog/aluExecStage.sv
verilog/execUnit.sv
tb/execUnitTb.sv

//--- tb/execUnit_cases.txt
# name class funct7 funct3 srcA srcB result error, all hex but the name
# class: 0 R-type, 1 I-type, 2 default add, 3 pass source 1
add     0 00 0 00000005 00000003 00000008 0
sub     0 20 0 00000005 00000007 fffffffe 0
sll     0 00 1 00000001 00000024 00000010 0
slt     0 00 2 ffffffff 00000001 00000001 0
sltu    0 00 3 ffffffff 00000001 00000000 0
xor     0 00 4 0f0f0f0f ff00ff00 f00ff00f 0
srl     0 00 5 80000000 00000004 08000000 0
sra     0 20 5 80000000 00000004 f8000000 0
and     0 00 7 ffff0000 00ff00ff 00ff0000 0
addi    1 00 0 00000010 fffffff0 00000000 0
sltiu   1 00 3 00000005 ffffffff 00000001 0
srai    1 20 5 f0000000 00000408 fff00000 0
mul     0 01 0 00000007 fffffffd ffffffeb 0
mulh    0 01 1 80000000 80000000 40000000 0
mulhsu  0 01 2 ffffffff ffffffff ffffffff 0
mulhu   0 01 3 ffffffff ffffffff fffffffe 0
div     0 01 4 fffffff9 00000002 fffffffd 0
divu    0 01 5 00000064 00000007 0000000e 0
rem     0 01 6 fffffff9 00000002 ffffffff 0
remu    0 01 7 00000064 00000007 00000002 0
divZero 0 01 4 00001234 00000000 ffffffff 0
divuZero 0 01 5 00001234 00000000 ffffffff 0
remZero 0 01 6 00001234 00000000 00001234 0
divOvf  0 01 4 80000000 ffffffff 80000000 0
remOvf  0 01 6 80000000 ffffffff 00000000 0
badF7   0 05 0 00000001 00000002 00000000 1
badAlt  0 20 1 00000001 00000002 00000000 1
badSubi 1 20 0 00000001 00000002 00000000 1
defAdd  2 7f 7 00000100 00000023 00000123 0
pass    3 55 2 deadbeef 12345678 deadbeef 0
